//--- logic/crx_cfg.svh
`ifndef CRX_CFG_SVH
`define CRX_CFG_SVH

// --------------------
// Receive buffer sizing
// --------------------

// Entries in each receive buffer.
// This is also the initial and the maximum credit of each flow.
`define CRX_BUF_DEPTH 4

// The count must hold the depth itself, so one more value than the depth.
`define CRX_CNT_W $clog2(`CRX_BUF_DEPTH + 1)

// --------------------
// Payload widths
// --------------------

// Flow 0 carries data flits and sets the width of the output bus.
`define CRX_DATA_W 32
// Flow 1 carries short messages.
`define CRX_MSG_W 16

`endif

//--- logic/crx_pkg.sv
`include "crx_cfg.svh"

package crx_pkg;

  // --------------------
  // Payload types
  // --------------------

  // Flow 0 payload, which is as wide as the output bus.
  typedef logic [`CRX_DATA_W-1:0] data_flit_t;

  // Flow 1 payload.
  // It is zero-extended on its way to the output bus.
  typedef logic [`CRX_MSG_W-1:0] msg_flit_t;

  // --------------------
  // Control types
  // --------------------

  // A credit count, from zero up to the buffer depth inclusive.
  typedef logic [`CRX_CNT_W-1:0] credit_t;

  // Names the flow that is shown on the output bus.
  typedef logic flow_id_t;

endpackage

//--- logic/credit_counter.sv
`timescale 1ns/1ps

`include "crx_cfg.svh"

module credit_counter import crx_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    reload,
  input  logic    incr,
  input  logic    decr,
  input  credit_t withhold,
  output credit_t value,
  output credit_t available
);

  // The sum is one bit wider so count plus incr never wraps.
  logic [`CRX_CNT_W:0] count_plus_incr;
  logic [`CRX_CNT_W:0] withhold_ext;
  credit_t             count_q;
  credit_t             count_next;

  // --------------------
  // Available credit
  // --------------------

  // A credit returned this cycle is usable this cycle.
  // This is what lets a credit pass straight through when the count is zero.
  assign count_plus_incr = {1'b0, count_q} + {{`CRX_CNT_W{1'b0}}, incr};
  assign withhold_ext    = {1'b0, withhold};

  // Withheld credits are taken off the top, and the result floors at zero.
  always_comb begin
    if (count_plus_incr > withhold_ext) begin
      available = credit_t'(count_plus_incr - withhold_ext);
    end else begin
      available = '0;
    end
  end

  // --------------------
  // Count register
  // --------------------

  // Increment and decrement land together at the next edge.
  // A decrement is only asked for while some credit is available.
  assign count_next = count_q + credit_t'(incr) - credit_t'(decr);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= credit_t'(`CRX_BUF_DEPTH);
    end else if (reload) begin
      // Reload puts the whole buffer back in circulation.
      count_q <= credit_t'(`CRX_BUF_DEPTH);
    end else begin
      count_q <= count_next;
    end
  end

  // The count seen outside is the state before this cycle's changes.
  assign value = count_q;

endmodule

//--- logic/credit_receiver.sv
`timescale 1ns/1ps

module credit_receiver import crx_pkg::*; #(
  parameter type payload_t = data_flit_t
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     sender_in_reset,
  input  logic     credit_stall,
  input  logic     push_valid,
  input  payload_t push_data,
  input  logic     pop_credit,
  input  credit_t  withhold,
  output logic     push_credit,
  output logic     receiver_in_reset,
  output logic     wr_en,
  output payload_t wr_data,
  output logic     flush,
  output credit_t  credit_count,
  output credit_t  credit_available
);

  logic either_rst;
  logic credit_give;
  logic pop_incr;

  // --------------------
  // Combined reset
  // --------------------

  // The receiver counts as in reset until the first edge after arst_n is released.
  // A sender reset holds this side in a synchronous reset as well.
  assign either_rst = sender_in_reset || receiver_in_reset;

  // Pops seen during reset are dropped, since the counter reloads anyway.
  assign pop_incr = pop_credit && !either_rst;

  credit_counter u_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .reload    (either_rst),
    .incr      (pop_incr),
    .decr      (credit_give),
    .withhold  (withhold),
    .value     (credit_count),
    .available (credit_available)
  );

  // One credit per cycle at most. Stall blocks it, and so does reset on either side.
  assign credit_give = (credit_available != '0) && !credit_stall && !either_rst;

  // --------------------
  // Push side
  // --------------------

  // No register on the data path. The push goes to the buffer in the same cycle.
  assign wr_en   = push_valid && !either_rst;
  assign wr_data = push_data;

  // The buffer empties itself while either side is in reset.
  assign flush = either_rst;

  // Both push outputs are registered toward the remote sender.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      receiver_in_reset <= 1'b1;
      push_credit       <= 1'b0;
    end else begin
      receiver_in_reset <= 1'b0;
      push_credit       <= credit_give;
    end
  end

endmodule

//--- logic/rx_buffer.sv
`timescale 1ns/1ps

`include "crx_cfg.svh"

module rx_buffer import crx_pkg::*; #(
  parameter type payload_t = data_flit_t
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     flush,
  input  logic     wr_en,
  input  logic     pop,
  input  payload_t wr_data,
  output payload_t head,
  output logic     empty
);

  localparam int PTR_W = (`CRX_BUF_DEPTH > 1) ? $clog2(`CRX_BUF_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`CRX_BUF_DEPTH - 1);

  payload_t         mem [`CRX_BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          count;
  logic             full;
  logic             do_wr;
  logic             do_pop;

  assign empty = (count == '0);
  assign full  = (count == credit_t'(`CRX_BUF_DEPTH));

  // A pop from an empty buffer is ignored.
  // A write into a full one only goes through if the same cycle also pops.
  assign do_pop = pop && !empty;
  assign do_wr  = wr_en && (!full || do_pop);

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // The head is read straight from the array, so the arbiter sees it this cycle.
  assign head = mem[rd_ptr];

  // --------------------
  // Pointers and occupancy
  // --------------------

  // The pointers wrap by compare, so the depth need not be a power of two.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + credit_t'(do_wr) - credit_t'(do_pop);
    end
  end

endmodule

//--- logic/out_arbiter.sv
`timescale 1ns/1ps

`include "crx_cfg.svh"

module out_arbiter import crx_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       empty0,
  input  logic       empty1,
  input  data_flit_t head0,
  input  msg_flit_t  head1,
  input  logic       out_stall,
  output logic       pop0,
  output logic       pop1,
  output logic       out_valid,
  output flow_id_t   out_flow,
  output data_flit_t out_data
);

  logic       req0;
  logic       req1;
  flow_id_t   last_served;
  data_flit_t head1_ext;

  // --------------------
  // Grant
  // --------------------

  // Nothing is requested while the consumer stalls.
  assign req0 = !empty0 && !out_stall;
  assign req1 = !empty1 && !out_stall;

  // When both flows wait, the one not served last wins.
  assign pop0 = req0 && (!req1 || (last_served == 1'b1));
  assign pop1 = req1 && (!req0 || (last_served == 1'b0));

  // Messages are narrower than the bus, so the upper bits are zero.
  assign head1_ext = {{(`CRX_DATA_W - `CRX_MSG_W){1'b0}}, head1};

  // --------------------
  // Output register
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid   <= 1'b0;
      last_served <= 1'b1;
    end else begin
      // The valid lasts one cycle per pop.
      out_valid <= pop0 || pop1;
      if (pop0 || pop1) begin
        last_served <= pop1;
      end
    end
  end

  // Flow id and data only move with a grant.
  always_ff @(posedge clk) begin
    if (pop0 || pop1) begin
      out_flow <= pop1;
      out_data <= pop1 ? head1_ext : head0;
    end
  end

endmodule

//--- logic/crx_top.sv
`timescale 1ns/1ps

module crx_top import crx_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push_sender_in_reset,
  input  logic       push_credit_stall,
  input  logic [1:0] push_valid,
  input  data_flit_t push_data0,
  input  msg_flit_t  push_data1,
  input  credit_t    withhold0,
  input  credit_t    withhold1,
  input  logic       out_stall,
  output logic [1:0] push_credit,
  output logic       push_receiver_in_reset,
  output logic       out_valid,
  output flow_id_t   out_flow,
  output data_flit_t out_data,
  output credit_t    credit_count0,
  output credit_t    credit_count1,
  output credit_t    credit_available0,
  output credit_t    credit_available1
);

  // Flow 0 wires, receiver to buffer to arbiter.
  logic       wr_en0;
  data_flit_t wr_data0;
  logic       flush0;
  logic       pop0;
  logic       empty0;
  data_flit_t head0;

  // Flow 1 wires.
  logic       wr_en1;
  msg_flit_t  wr_data1;
  logic       flush1;
  logic       pop1;
  logic       empty1;
  msg_flit_t  head1;

  // --------------------
  // Flow 0, data
  // --------------------

  credit_receiver #(.payload_t(data_flit_t)) u_rx0 (
    .clk               (clk),
    .arst_n            (arst_n),
    .sender_in_reset   (push_sender_in_reset),
    .credit_stall      (push_credit_stall),
    .push_valid        (push_valid[0]),
    .push_data         (push_data0),
    .pop_credit        (pop0),
    .withhold          (withhold0),
    .push_credit       (push_credit[0]),
    .receiver_in_reset (push_receiver_in_reset),
    .wr_en             (wr_en0),
    .wr_data           (wr_data0),
    .flush             (flush0),
    .credit_count      (credit_count0),
    .credit_available  (credit_available0)
  );

  rx_buffer #(.payload_t(data_flit_t)) u_buf0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .flush   (flush0),
    .wr_en   (wr_en0),
    .pop     (pop0),
    .wr_data (wr_data0),
    .head    (head0),
    .empty   (empty0)
  );

  // --------------------
  // Flow 1, messages
  // --------------------

  // Its in-reset output matches flow 0's, so only flow 0 drives the port.
  credit_receiver #(.payload_t(msg_flit_t)) u_rx1 (
    .clk               (clk),
    .arst_n            (arst_n),
    .sender_in_reset   (push_sender_in_reset),
    .credit_stall      (push_credit_stall),
    .push_valid        (push_valid[1]),
    .push_data         (push_data1),
    .pop_credit        (pop1),
    .withhold          (withhold1),
    .push_credit       (push_credit[1]),
    .receiver_in_reset (),
    .wr_en             (wr_en1),
    .wr_data           (wr_data1),
    .flush             (flush1),
    .credit_count      (credit_count1),
    .credit_available  (credit_available1)
  );

  rx_buffer #(.payload_t(msg_flit_t)) u_buf1 (
    .clk     (clk),
    .arst_n  (arst_n),
    .flush   (flush1),
    .wr_en   (wr_en1),
    .pop     (pop1),
    .wr_data (wr_data1),
    .head    (head1),
    .empty   (empty1)
  );

  // --------------------
  // Shared output
  // --------------------

  // Each pop from the arbiter also returns one credit to its flow.
  out_arbiter u_arb (
    .clk       (clk),
    .arst_n    (arst_n),
    .empty0    (empty0),
    .empty1    (empty1),
    .head0     (head0),
    .head1     (head1),
    .out_stall (out_stall),
    .pop0      (pop0),
    .pop1      (pop1),
    .out_valid (out_valid),
    .out_flow  (out_flow),
    .out_data  (out_data)
  );

endmodule

//--- tb/crx_tb.sv
`timescale 1ns/1ps

`include "crx_cfg.svh"

module crx_tb import crx_pkg::*; ();

  localparam int DEPTH   = `CRX_BUF_DEPTH;
  localparam int WH      = `CRX_BUF_DEPTH / 2;
  localparam int TIMEOUT = 200;

  logic       clk = 1'b0;
  logic       arst_n;
  logic       push_sender_in_reset;
  logic       push_credit_stall;
  logic [1:0] push_valid;
  data_flit_t push_data0;
  msg_flit_t  push_data1;
  credit_t    withhold0;
  credit_t    withhold1;
  logic       out_stall;
  logic [1:0] push_credit;
  logic       push_receiver_in_reset;
  logic       out_valid;
  flow_id_t   out_flow;
  data_flit_t out_data;
  credit_t    credit_count0;
  credit_t    credit_count1;
  credit_t    credit_available0;
  credit_t    credit_available1;

  // Sender side model: credits received, flits sent and flits seen on the output.
  // The credits the sender holds are rcvd minus sent.
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          rcvd [2];
  int          sent [2];
  int          delivered [2];
  data_flit_t  exp_q0 [$];
  data_flit_t  exp_q1 [$];
  flow_id_t    flow_log [$];

  crx_top UUT (
    .clk                    (clk),
    .arst_n                 (arst_n),
    .push_sender_in_reset   (push_sender_in_reset),
    .push_credit_stall      (push_credit_stall),
    .push_valid             (push_valid),
    .push_data0             (push_data0),
    .push_data1             (push_data1),
    .withhold0              (withhold0),
    .withhold1              (withhold1),
    .out_stall              (out_stall),
    .push_credit            (push_credit),
    .push_receiver_in_reset (push_receiver_in_reset),
    .out_valid              (out_valid),
    .out_flow               (out_flow),
    .out_data               (out_data),
    .credit_count0          (credit_count0),
    .credit_count1          (credit_count1),
    .credit_available0      (credit_available0),
    .credit_available1      (credit_available1)
  );

  // 4 ns clock.
  initial begin
    forever #2 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  // Galois LFSR, one step per bit taken; the bits fill the result from the bottom.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] want,
                             input logic [31:0] got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error: %s expected 0x%h got 0x%h", name, want, got);
    end
  endtask

  task automatic clear_model();
    for (int f = 0; f < 2; f++) begin
      rcvd[f]      = 0;
      sent[f]      = 0;
      delivered[f] = 0;
    end
    exp_q0.delete();
    exp_q1.delete();
    flow_log.delete();
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Sends one flit on flow f as soon as the sender holds a credit.
  task automatic push_flit(input int f);
    int          n;
    logic [31:0] d;
    n = 0;
    @(posedge clk);
    while (rcvd[f] - sent[f] <= 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rcvd[f] - sent[f] <= 0) begin
      errors++;
      $display("Timed out waiting for a credit on flow %0d", f);
    end else begin
      sent[f]++;
      if (f == 0) begin
        d = rand_bits(32);
        push_data0 <= d;
        exp_q0.push_back(d);
      end else begin
        // The upper half is already zero, as on the output bus.
        d = rand_bits(16);
        push_data1 <= d[15:0];
        exp_q1.push_back(d);
      end
      push_valid[f] <= 1'b1;
      @(posedge clk);
      push_valid[f] <= 1'b0;
    end
  endtask

  task automatic wait_balance(input int f, input int target);
    int n;
    n = 0;
    while (rcvd[f] - sent[f] != target && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (rcvd[f] - sent[f] != target) begin
      errors++;
      $display("Timed out waiting for flow %0d to hold %0d credits", f, target);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q0.size() + exp_q1.size() != 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (exp_q0.size() + exp_q1.size() != 0) begin
      errors++;
      $display("Timed out with flits still expected on the output bus");
    end
  endtask

  // --------------------
  // Monitor
  // --------------------

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk) begin
    data_flit_t want;
    for (int f = 0; f < 2; f++) begin
      if (push_credit[f]) begin
        rcvd[f]++;
      end
    end
    if (out_valid) begin
      flow_log.push_back(out_flow);
      delivered[out_flow]++;
      if (out_flow == 1'b0 && exp_q0.size() == 0) begin
        errors++;
        $display("Output flit on flow 0 with nothing expected");
      end else if (out_flow == 1'b1 && exp_q1.size() == 0) begin
        errors++;
        $display("Output flit on flow 1 with nothing expected");
      end else if (out_flow == 1'b0) begin
        want = exp_q0.pop_front();
        check_value("out_data", want, out_data);
      end else begin
        want = exp_q1.pop_front();
        check_value("out_data", want, out_data);
      end
    end
    // Credits not yet matched by a delivered flit can never exceed the depth.
    for (int f = 0; f < 2; f++) begin
      if (rcvd[f] - delivered[f] > DEPTH) begin
        errors++;
        $display("Flow %0d was given more credits than the buffer holds", f);
      end
    end
  end

  // --------------------
  // Tests
  // --------------------

  task automatic reset_credit_test();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value("push_receiver_in_reset", 1, 32'(push_receiver_in_reset));
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    // The receiver stays in reset for the first cycle after release.
    @(negedge clk);
    check_value("push_receiver_in_reset", 1, 32'(push_receiver_in_reset));
    @(negedge clk);
    check_value("push_receiver_in_reset", 0, 32'(push_receiver_in_reset));
    wait_balance(0, DEPTH);
    wait_balance(1, DEPTH);
    idle(8);
    @(negedge clk);
    if (rcvd[0] != DEPTH || rcvd[1] != DEPTH) begin
      errors++;
      $display("Initial credits were not exactly the buffer depth");
    end
    check_value("credit_count0", 0, 32'(credit_count0));
    check_value("credit_count1", 0, 32'(credit_count1));
  endtask

  task automatic data_arbitration_test();
    for (int i = 0; i < 6; i++) begin
      push_flit(0);
      push_flit(1);
    end
    wait_drain();
    wait_balance(0, DEPTH);
    wait_balance(1, DEPTH);
    // Late extra credits would show up during this quiet time.
    idle(6);
    @(negedge clk);
    if (rcvd[0] - delivered[0] != DEPTH || rcvd[1] - delivered[1] != DEPTH) begin
      errors++;
      $display("Delivered flits did not each return one credit");
    end
    // Two flits per flow wait behind the stall, then leave in turn.
    @(posedge clk);
    out_stall <= 1'b1;
    push_flit(0);
    push_flit(0);
    push_flit(1);
    push_flit(1);
    idle(2);
    flow_log.delete();
    out_stall <= 1'b0;
    wait_drain();
    @(negedge clk);
    checks++;
    if (flow_log.size() != 4) begin
      errors++;
      $display("Expected four flits after the stall, saw %0d", flow_log.size());
    end else begin
      for (int i = 1; i < 4; i++) begin
        if (flow_log[i] == flow_log[i-1]) begin
          errors++;
          $display("Flows did not alternate while both were pending");
        end
      end
    end
    wait_balance(0, DEPTH);
    wait_balance(1, DEPTH);
  endtask

  task automatic back_pressure_test();
    int base;
    @(posedge clk);
    out_stall <= 1'b1;
    @(posedge clk);
    base = delivered[0] + delivered[1];
    for (int i = 0; i < DEPTH; i++) begin
      push_flit(0);
      push_flit(1);
    end
    idle(8);
    @(negedge clk);
    if (delivered[0] + delivered[1] != base) begin
      errors++;
      $display("Output flit appeared while out_stall was high");
    end
    if (rcvd[0] != sent[0] || rcvd[1] != sent[1]) begin
      errors++;
      $display("Credits were given while the buffers were full");
    end
    @(posedge clk);
    out_stall <= 1'b0;
    wait_drain();
    wait_balance(0, DEPTH);
    wait_balance(1, DEPTH);
  endtask

  task automatic withhold_test();
    @(posedge clk);
    withhold0 <= credit_t'(WH);
    for (int i = 0; i < DEPTH; i++) begin
      push_flit(0);
    end
    wait_drain();
    wait_balance(0, DEPTH - WH);
    idle(6);
    @(negedge clk);
    if (rcvd[0] - sent[0] != DEPTH - WH) begin
      errors++;
      $display("Flow 0 holds more credits than withhold allows");
    end
    check_value("credit_count0", WH, 32'(credit_count0));
    check_value("credit_available0", 0, 32'(credit_available0));
    // Withholding more than the count still floors at zero.
    @(posedge clk);
    withhold0 <= credit_t'(WH + 1);
    @(negedge clk);
    check_value("credit_available0", 0, 32'(credit_available0));
    @(posedge clk);
    withhold0 <= credit_t'(WH - 1);
    @(negedge clk);
    check_value("credit_available0", 1, 32'(credit_available0));
    @(posedge clk);
    withhold0 <= '0;
    wait_balance(0, DEPTH);
    idle(6);
    @(negedge clk);
    if (rcvd[0] - sent[0] != DEPTH) begin
      errors++;
      $display("Flow 0 got the wrong number of credits after withhold cleared");
    end
  endtask

  task automatic credit_stall_test();
    @(posedge clk);
    push_credit_stall <= 1'b1;
    push_flit(0);
    push_flit(1);
    push_flit(0);
    push_flit(1);
    wait_drain();
    idle(6);
    @(negedge clk);
    if (rcvd[0] - sent[0] != DEPTH - 2 || rcvd[1] - sent[1] != DEPTH - 2) begin
      errors++;
      $display("push_credit strobed while push_credit_stall was high");
    end
    check_value("credit_count0", 2, 32'(credit_count0));
    check_value("credit_available1", 2, 32'(credit_available1));
    @(posedge clk);
    push_credit_stall <= 1'b0;
    wait_balance(0, DEPTH);
    wait_balance(1, DEPTH);
  endtask

  task automatic sender_reset_test();
    int base_credits;
    int base_out;
    @(posedge clk);
    out_stall <= 1'b1;
    push_flit(0);
    push_flit(1);
    push_flit(0);
    push_flit(1);
    @(posedge clk);
    push_sender_in_reset <= 1'b1;
    @(negedge clk);
    base_credits = rcvd[0] + rcvd[1];
    base_out     = delivered[0] + delivered[1];
    // This push falls inside the sender reset and must vanish.
    @(posedge clk);
    push_valid <= 2'b11;
    push_data0 <= rand_bits(32);
    push_data1 <= msg_flit_t'(rand_bits(16));
    @(posedge clk);
    push_valid <= 2'b00;
    out_stall  <= 1'b0;
    idle(4);
    @(negedge clk);
    if (rcvd[0] + rcvd[1] != base_credits) begin
      errors++;
      $display("push_credit strobed during sender reset");
    end
    if (delivered[0] + delivered[1] != base_out) begin
      errors++;
      $display("Output flit appeared during sender reset");
    end
    @(posedge clk);
    push_sender_in_reset <= 1'b0;
    clear_model();
    wait_balance(0, DEPTH);
    wait_balance(1, DEPTH);
    idle(8);
    @(negedge clk);
    if (rcvd[0] != DEPTH || rcvd[1] != DEPTH) begin
      errors++;
      $display("Credits after sender reset were not exactly the buffer depth");
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    arst_n               = 1'b0;
    push_sender_in_reset = 1'b0;
    push_credit_stall    = 1'b0;
    push_valid           = 2'b00;
    push_data0           = '0;
    push_data1           = '0;
    withhold0            = '0;
    withhold1            = '0;
    out_stall            = 1'b0;
    lfsr_state           = 32'd83184;
    errors               = 0;
    checks               = 0;
    clear_model();

    reset_credit_test();
    data_arbitration_test();
    back_pressure_test();
    withhold_test();
    credit_stall_test();
    sender_reset_test();
    idle(4);

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- crx_top.f
+incdir+logic
logic/crx_pkg.sv
logic/credit_counter.sv
logic/credit_receiver.sv
logic/rx_buffer.sv
logic/out_arbiter.sv
logic/crx_top.sv
tb/crx_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the crx_top testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module crx_tb -f crx_top.f -o crx_sim

out="$(./obj_dir/crx_sim)"
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi
